// ==== run_sim.sh ====
#!/bin/sh
# Builds the instruction cache testbench with Verilator, runs it,
# and looks for the pass message in the simulation output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_icache -f sources.f -o tb_icache_sim
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

sim_out=$(./obj_dir/tb_icache_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qF '*** TEST PASSED ***'; then
	exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// ==== sim/bus_memory_model.sv ====
// --------------------------------------------------
// Bus slave for the cache testbench.
// Grants and answers reads with random gaps; each
// word is its address XOR-ed with a fixed key.
// --------------------------------------------------

module bus_memory_model #(
	parameter logic [31:0] DATA_KEY = 32'h5A3C_96E1	// Folded into every address.
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] bus_addr,	// Word address of the read.
	input  logic        bus_rd,	// Read strobe from the cache.
	output logic        bus_ack,	// Grant level, random gaps.
	output logic        bus_ready,	// Beat strobe, random gaps.
	output logic [31:0] bus_rdata	// Read data for bus_addr.
);
	timeunit 1ns;
	timeprecision 1ps;

	// --------------------------------------------------
	// Read data.
	// --------------------------------------------------
	// Every address bit lands in the data word, so a beat that goes to
	// the wrong word or line shows up as a data mismatch later.
	assign bus_rdata = bus_rd ? (bus_addr ^ DATA_KEY) : '0;	// Zero when idle.

	// --------------------------------------------------
	// Grant and ready.
	// --------------------------------------------------
	// Both levels change one step after the rising edge, like the rest
	// of the stimulus, and never depend on what the cache drives.
	initial begin
		bus_ack   = 1'b0;	// Quiet until reset is released.
		bus_ready = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			if (!rst_n) begin
				bus_ack   = 1'b0;	// Held off during reset.
				bus_ready = 1'b0;
			end else begin
				bus_ack   = ($urandom % 4) != 0;	// Granted about three cycles in four.
				bus_ready = ($urandom % 3) != 0;	// Ready about two cycles in three.
			end
		end
	end

endmodule

// ==== sim/tb_icache.sv ====
// --------------------------------------------------
// Testbench of the instruction cache.
// Clock, reset, scripted and random fetch runs,
// a model of the filled lines, concurrent checks.
// --------------------------------------------------

module tb_icache import icache_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] DATA_KEY   = 32'h5A3C_96E1;	// Memory word rule.
	localparam int          SEED       = 45379;
	localparam int          WAIT_LIMIT = 400;	// Cycles allowed for one fetch.

	logic        clk;
	logic        rst_n;
	logic [31:0] rd_addr;
	logic        rd_req;
	logic        rd_wait;
	logic [31:0] rd_data;
	logic        flush;
	logic        bus_req;
	logic        bus_ack;
	logic [31:0] bus_addr;
	logic [31:0] bus_rdata;
	logic        bus_rd;
	logic        bus_ready;

	string test_name;	// Printed in every error line.
	int    data_errors    = 0;
	int    order_errors   = 0;
	int    hit_errors     = 0;
	int    idle_errors    = 0;
	int    timeout_errors = 0;

	icache_top UUT (.*);

	bus_memory_model #(.DATA_KEY(DATA_KEY)) u_memory (
		.clk       (clk),
		.rst_n     (rst_n),
		.bus_addr  (bus_addr),
		.bus_rd    (bus_rd),
		.bus_ack   (bus_ack),
		.bus_ready (bus_ready),
		.bus_rdata (bus_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;	// 10 ns period.
	end

	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		return {addr[31:2], 2'b00} ^ DATA_KEY;	// Byte offset cleared first.
	endfunction

	// --------------------------------------------------
	// Reference model of fill order and filled lines.
	// --------------------------------------------------
	logic                  beat;	// Ready beat of a bus read.
	logic                  track_q;	// A miss was pending last cycle.
	logic [25:0]           track_line_q;	// Line that miss named.
	logic [3:0]            beats_q;	// Ready beats since that miss began.
	logic [3:0]            exp_word;	// Word the current beat must read.
	logic [LINE_COUNT-1:0] known_v;	// Lines known to be filled.
	logic [TAG_W-1:0]      known_tag [LINE_COUNT];
	logic                  known_hit;

	assign beat      = bus_rd && bus_ready;
	assign exp_word  = (track_q && track_line_q == rd_addr[31:6]) ? beats_q : 4'd0;
	assign known_hit = known_v[rd_addr[9:6]] && (known_tag[rd_addr[9:6]] == rd_addr[31:10]);

	always_ff @(posedge clk) begin
		if (!rst_n || !bus_req) begin
			track_q <= 1'b0;	// A dropped miss starts over at word 0.
			beats_q <= '0;
		end else begin
			track_q      <= 1'b1;
			track_line_q <= rd_addr[31:6];
			beats_q      <= exp_word + {3'd0, beat};	// Wraps to 0 after word 15.
		end
	end

	// The sixteenth beat makes the line valid, even next to a flush.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			known_v <= '0;
		end else begin
			if (flush) begin
				known_v <= '0;
			end
			if (beat && exp_word == 4'd15) begin
				known_v[rd_addr[9:6]]   <= 1'b1;
				known_tag[rd_addr[9:6]] <= rd_addr[31:10];
			end
		end
	end

	// --------------------------------------------------
	// Checks.
	// --------------------------------------------------
	data_check: assert property (@(posedge clk) disable iff (!rst_n)
		(rd_req && !rd_wait) |-> (rd_data == mem_word(rd_addr)))
	else begin
		data_errors = data_errors + 1;
		$display("Mismatch %s data at %h: expected %h, actual %h", test_name,
			$sampled(rd_addr), mem_word($sampled(rd_addr)), $sampled(rd_data));
	end

	order_check: assert property (@(posedge clk) disable iff (!rst_n)
		beat |-> (bus_addr == {rd_addr[31:6], exp_word, 2'b00}))
	else begin
		order_errors = order_errors + 1;
		$display("Mismatch %s fill address: expected %h, actual %h", test_name,
			{$sampled(rd_addr[31:6]), $sampled(exp_word), 2'b00}, $sampled(bus_addr));
	end

	hit_check: assert property (@(posedge clk) disable iff (!rst_n)
		(rd_req && known_hit) |-> (!rd_wait && !bus_req))
	else begin
		hit_errors = hit_errors + 1;
		$display("Mismatch %s hit at %h: expected wait,req 00, actual %b%b", test_name,
			$sampled(rd_addr), $sampled(rd_wait), $sampled(bus_req));
	end

	miss_check: assert property (@(posedge clk) disable iff (!rst_n)
		(rd_req && !known_hit) |-> (rd_wait && bus_req))
	else begin
		hit_errors = hit_errors + 1;
		$display("Mismatch %s miss at %h: expected wait,req 11, actual %b%b", test_name,
			$sampled(rd_addr), $sampled(rd_wait), $sampled(bus_req));
	end

	idle_check: assert property (@(posedge clk) disable iff (!rst_n)
		!rd_req |-> (!bus_req && !bus_rd && !rd_wait))
	else begin
		idle_errors = idle_errors + 1;
		$display("Mismatch %s idle: expected req,rd,wait 000, actual %b%b%b", test_name,
			$sampled(bus_req), $sampled(bus_rd), $sampled(rd_wait));
	end

	// --------------------------------------------------
	// Stimulus tasks, called one step after a rising edge.
	// --------------------------------------------------
	task automatic close_run();
		int total;
		total = data_errors + order_errors + hit_errors + idle_errors + timeout_errors;
		$display("Errors: data %0d, fill order %0d, hit and miss %0d, idle %0d, timeout %0d",
			data_errors, order_errors, hit_errors, idle_errors, timeout_errors);
		if (total == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	endtask

	// Holds the address until rd_wait is low at a falling edge.
	task automatic fetch(input logic [31:0] addr);
		int cycles;
		cycles  = 0;
		rd_addr = addr;
		rd_req  = 1'b1;
		@(negedge clk);
		while (rd_wait && cycles < WAIT_LIMIT) begin
			cycles = cycles + 1;
			@(negedge clk);
		end
		if (rd_wait) begin
			timeout_errors = timeout_errors + 1;
			$display("Error in %s: fetch of %h did not complete in time", test_name, addr);
			close_run();
		end else begin
			@(posedge clk);
			#1;
		end
	endtask

	// Starts a fill, then moves to another line or drops the request.
	task automatic broken_fetch(input logic [31:0] first, input logic [31:0] second,
		input int cycles, input logic drop);
		rd_addr = first;
		rd_req  = 1'b1;
		repeat (cycles) @(posedge clk);
		#1;
		if (drop) begin
			rd_req = 1'b0;	// One idle cycle forgets the partial line.
			@(posedge clk);
			#1;
		end
		fetch(second);
	endtask

	task automatic flush_pulse();
		rd_req = 1'b0;
		flush  = 1'b1;
		@(posedge clk);
		#1;
		flush = 1'b0;
	endtask

	// --------------------------------------------------
	// Test sequence.
	// --------------------------------------------------
	initial begin
		logic [31:0] addr;
		void'($urandom(SEED));
		rd_addr   = '0;
		rd_req    = 1'b0;
		flush     = 1'b0;
		rst_n     = 1'b0;
		test_name = "reset";
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (4) @(posedge clk);	// Idle after reset, bus stays quiet.
		#1;

		test_name = "sequential";	// Two lines, one miss each.
		for (int i = 0; i < 32; i++) begin
			fetch(32'h0000_1000 + 32'(4 * i));
		end

		test_name = "hit_after_fill";
		for (int i = 31; i >= 0; i--) begin
			fetch(32'h0000_1000 + 32'(4 * i));
		end

		test_name = "conflict";	// Same index 0, other tag.
		fetch(32'h0000_5008);
		fetch(32'h0000_1008);
		fetch(32'h0000_5008);

		test_name = "fill_restart";
		broken_fetch(32'h0000_2200, 32'h0000_2644, 6, 1'b0);
		broken_fetch(32'h0000_3100, 32'h0000_3104, 5, 1'b1);

		test_name = "flush";
		fetch(32'h0000_1040);
		flush_pulse();
		fetch(32'h0000_1040);
		fetch(32'h0000_1044);

		test_name = "random";
		for (int n = 0; n < 300; n++) begin
			if ($urandom % 50 == 0) begin
				flush_pulse();
			end
			addr = 32'h0004_0000 | (($urandom % 4) << 10) | (($urandom % 16) << 6) |
				(($urandom % 16) << 2) | ($urandom % 4);
			fetch(addr);
		end

		rd_req = 1'b0;
		repeat (4) @(posedge clk);
		close_run();
	end

endmodule

// ==== source/icache_line_fill.sv ====
// --------------------------------------------------
// Fill stage of the instruction cache.
// Reads a missing line over the bus, word 0 first,
// and restarts whenever the missing line changes.
// --------------------------------------------------

module icache_line_fill import icache_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,

	// From the lookup stage.
	input  miss_t       miss,	// Line the fetcher waits on.

	// Bus port.
	output logic        bus_req,	// Request while a miss is pending.
	input  logic        bus_ack,	// Grant, a level from outside.
	output logic [31:0] bus_addr,	// Word address of the current beat.
	input  logic [31:0] bus_rdata,	// Read data, valid with bus_ready.
	output logic        bus_rd,	// Read strobe while granted.
	input  logic        bus_ready,	// One beat delivered this cycle.

	// To the lookup stage.
	output fill_wr_t    fill_wr	// Word to write this cycle.
);

	// --------------------------------------------------
	// Fill state.
	// --------------------------------------------------
	logic               active_q;	// Some beats of a line are already in.
	logic [WORD_W-1:0]  pos_q;	// Next word position to read.
	logic [TAG_W-1:0]   line_tag_q;	// Tag of the line in progress.
	logic [INDEX_W-1:0] line_index_q;	// Index of the line in progress.

	logic               same_line;	// Miss still names the line in progress.
	logic [WORD_W-1:0]  pos;	// Position used for this cycle's beat.
	logic               beat;	// A ready beat is taken this cycle.
	icache_addr_u       beat_addr;	// Address of the word being read.

	// A new or changed line starts at word 0 at once, so the beat of this
	// very cycle already goes to the right word.
	assign same_line = active_q && (line_tag_q == miss.tag) &&
		(line_index_q == miss.index);
	assign pos       = same_line ? pos_q : '0;

	// --------------------------------------------------
	// Bus side.
	// --------------------------------------------------
	assign bus_req = miss.valid;	// Level for the whole miss.
	assign bus_rd  = miss.valid && bus_ack;	// Read once granted.
	assign beat    = bus_rd && bus_ready;	// Ready only counts during a read.

	always_comb begin
		beat_addr.fields.tag      = miss.tag;	// Line base from the miss.
		beat_addr.fields.index    = miss.index;
		beat_addr.fields.word     = pos;	// Plus four times the position.
		beat_addr.fields.byte_off = 2'b00;	// Word aligned reads.
		bus_addr = bus_rd ? beat_addr.raw : '0;	// Idle bus shows zero.
	end

	// --------------------------------------------------
	// Fill write to the lookup stage.
	// --------------------------------------------------
	always_comb begin
		fill_wr.valid = beat;	// Write only on a ready beat.
		fill_wr.index = miss.index;	// Slot of the missing line.
		fill_wr.word  = pos;	// Same word the bus just returned.
		fill_wr.data  = bus_rdata;	// Captured at the next edge.
		fill_wr.last  = (pos == WORD_W'(WORDS_PER_LINE - 1));	// Word 15.
		fill_wr.tag   = miss.tag;	// Installed with the last word.
	end

	// --------------------------------------------------
	// Position and line tracking.
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active_q <= 1'b0;	// No line in progress.
			pos_q    <= '0;	// Next fill starts at word 0.
		end else if (!miss.valid) begin
			active_q <= 1'b0;	// Request dropped or hit, forget the line.
			pos_q    <= '0;
		end else if (beat) begin
			active_q <= !fill_wr.last;	// Done after word 15.
			pos_q    <= pos + WORD_W'(1);	// Wraps to 0 after the last word.
		end else if (!same_line) begin
			active_q <= 1'b0;	// Line changed without a beat.
			pos_q    <= '0;
		end
	end

	// Remember which line the stored position belongs to.
	always_ff @(posedge clk) begin
		if (beat) begin
			line_tag_q   <= miss.tag;
			line_index_q <= miss.index;
		end
	end

endmodule

// ==== source/icache_lookup.sv ====
// --------------------------------------------------
// Lookup stage of the instruction cache.
// Holds the valid bits, tag array and data array,
// detects hits, raises misses and takes fill beats.
// --------------------------------------------------

module icache_lookup import icache_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,

	// Fetch port.
	input  icache_addr_u rd_addr,	// Held by the fetcher while stalled.
	input  logic         rd_req,	// Level, one fetch per low rd_wait.
	output logic         rd_wait,	// High while the line is missing.
	output logic [31:0]  rd_data,	// Valid when rd_req and not rd_wait.

	// Control.
	input  logic         flush,	// Drops every line in one edge.

	// Stage links.
	input  fill_wr_t     fill_wr,	// Beats from the fill stage.
	output miss_t        miss	// Missing line, to the fill stage.
);

	// --------------------------------------------------
	// Storage.
	// --------------------------------------------------
	logic [LINE_COUNT-1:0] valid_q;	// One bit per line.
	logic [TAG_W-1:0]      tag_mem  [LINE_COUNT];	// Tag of each line.
	logic [31:0]           data_mem [LINE_COUNT][WORDS_PER_LINE];	// Line words.

	// Fields of the fetch address.
	logic [TAG_W-1:0]   rd_tag;
	logic [INDEX_W-1:0] rd_index;
	logic [WORD_W-1:0]  rd_word;

	logic hit;	// Indexed line is valid and its tag matches.

	assign rd_tag   = rd_addr.fields.tag;	// Bits 31 to 10.
	assign rd_index = rd_addr.fields.index;	// Bits 9 to 6.
	assign rd_word  = rd_addr.fields.word;	// Bits 5 to 2.

	// --------------------------------------------------
	// Hit detection and fetch response.
	// --------------------------------------------------
	always_comb begin
		hit = valid_q[rd_index] && (tag_mem[rd_index] == rd_tag);	// Tag compare.
	end

	always_comb begin
		rd_wait = rd_req && !hit;	// Stall the fetcher until the line lands.
		rd_data = data_mem[rd_index][rd_word];	// Same-cycle read on a hit.
	end

	// A stalled fetch names the line the fill stage must bring in.
	always_comb begin
		miss.valid = rd_req && !hit;	// Same condition as the stall.
		miss.tag   = rd_tag;	// Tag to install on completion.
		miss.index = rd_index;	// Line slot to fill.
	end

	// --------------------------------------------------
	// Valid bits.
	// --------------------------------------------------
	// Flush clears all lines, but a fill finishing in the same cycle
	// still marks its own line, since the later assignment wins.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;	// Cache starts empty.
		end else begin
			if (flush) begin
				valid_q <= '0;	// Drop every line.
			end
			if (fill_wr.valid && fill_wr.last) begin
				valid_q[fill_wr.index] <= 1'b1;	// Line now complete.
			end
		end
	end

	// --------------------------------------------------
	// Tag and data writes.
	// --------------------------------------------------
	// The tag only changes with the final word, so a partly filled line
	// never compares as a hit with a stale tag and a fresh valid bit.
	always_ff @(posedge clk) begin
		if (fill_wr.valid && fill_wr.last) begin
			tag_mem[fill_wr.index] <= fill_wr.tag;	// Install with the 16th word.
		end
	end

	always_ff @(posedge clk) begin
		if (fill_wr.valid) begin
			data_mem[fill_wr.index][fill_wr.word] <= fill_wr.data;	// One word per beat.
		end
	end

endmodule

// ==== source/icache_pkg.sv ====
// --------------------------------------------------
// Shared definitions of the instruction cache.
// Geometry constants, the fetch address union, and
// the structs on the lookup and fill stage links.
// --------------------------------------------------

package icache_pkg;

	// --------------------------------------------------
	// Geometry.
	// --------------------------------------------------
	localparam int LINE_COUNT     = 16;	// Direct mapped, one way.
	localparam int WORDS_PER_LINE = 16;	// 64-byte lines of 32-bit words.
	localparam int TAG_W          = 22;	// Address bits 31 to 10.
	localparam int INDEX_W        = 4;	// Address bits 9 to 6.
	localparam int WORD_W         = 4;	// Address bits 5 to 2.

	// --------------------------------------------------
	// Address views.
	// --------------------------------------------------
	typedef struct packed {
		logic [TAG_W-1:0]   tag;	// Compared against the stored tag.
		logic [INDEX_W-1:0] index;	// Selects the cache line.
		logic [WORD_W-1:0]  word;	// Selects the word in the line.
		logic [1:0]         byte_off;	// Ignored, fetches are word wide.
	} icache_addr_fields_t;

	// The same 32 bits, either as a flat bus address or split for lookup.
	typedef union packed {
		logic [31:0]         raw;	// Flat address for the bus side.
		icache_addr_fields_t fields;	// Split address for the arrays.
	} icache_addr_u;

	// --------------------------------------------------
	// Stage links.
	// --------------------------------------------------
	// Lookup to fill: the line the fetcher is stalled on.
	typedef struct packed {
		logic               valid;	// A fetch is requested and missed.
		logic [TAG_W-1:0]   tag;	// Tag of the missing line.
		logic [INDEX_W-1:0] index;	// Index of the missing line.
	} miss_t;

	// Fill to lookup: one word written per ready beat.
	typedef struct packed {
		logic               valid;	// A beat is written this cycle.
		logic [INDEX_W-1:0] index;	// Line being filled.
		logic [WORD_W-1:0]  word;	// Word position in the line.
		logic [31:0]        data;	// Word returned by the bus.
		logic               last;	// Final word, installs tag and valid.
		logic [TAG_W-1:0]   tag;	// Tag written with the final word.
	} fill_wr_t;

endpackage

// ==== source/icache_top.sv ====
// --------------------------------------------------
// Top level of the instruction cache.
// Joins the lookup and fill stages to the fetch
// port and the bus port.
// --------------------------------------------------

module icache_top import icache_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,

	// --------------------------------------------------
	// Fetch port.
	// --------------------------------------------------
	input  logic [31:0] rd_addr,	// Fetch address, held while stalled.
	input  logic        rd_req,	// Fetch request level.
	output logic        rd_wait,	// Stall, high during a miss.
	output logic [31:0] rd_data,	// Fetched word.
	input  logic        flush,	// Invalidate the whole cache.

	// --------------------------------------------------
	// Bus port.
	// --------------------------------------------------
	output logic        bus_req,	// Bus request level.
	input  logic        bus_ack,	// Bus grant level.
	output logic [31:0] bus_addr,	// Read address.
	input  logic [31:0] bus_rdata,	// Read data.
	output logic        bus_rd,	// Read strobe.
	input  logic        bus_ready	// Read data valid.
);

	icache_addr_u fetch_addr;	// Fetch address in its split view.
	miss_t        miss;	// Lookup to fill, the missing line.
	fill_wr_t     fill_wr;	// Fill to lookup, one word per beat.

	assign fetch_addr = icache_addr_u'(rd_addr);	// Same bits, union type.

	// Lookup stage, owns the arrays.
	icache_lookup u_lookup (
		.clk     (clk),
		.rst_n   (rst_n),
		.rd_addr (fetch_addr),
		.rd_req  (rd_req),
		.rd_wait (rd_wait),
		.rd_data (rd_data),
		.flush   (flush),
		.fill_wr (fill_wr),
		.miss    (miss)
	);

	// Fill stage, owns the bus.
	icache_line_fill u_line_fill (
		.clk       (clk),
		.rst_n     (rst_n),
		.miss      (miss),
		.bus_req   (bus_req),
		.bus_ack   (bus_ack),
		.bus_addr  (bus_addr),
		.bus_rdata (bus_rdata),
		.bus_rd    (bus_rd),
		.bus_ready (bus_ready),
		.fill_wr   (fill_wr)
	);

endmodule

// ==== sources.f ====
source/icache_pkg.sv
source/icache_lookup.sv
source/icache_line_fill.sv
source/icache_top.sv
sim/bus_memory_model.sv
sim/tb_icache.sv
